//--- design/access_arbiter.sv
// Access category arbiter
`timescale 1ns/10ps
`default_nettype none

`include "csma_defines.svh"

module access_arbiter (
  input  wire logic                    clk,
  input  wire logic                    rstn,
  input  wire logic [`CSMA_NUM_AC-1:0] ready,
  input  wire logic                    medium_idle,
  output logic [`CSMA_NUM_AC-1:0]      grant,
  output csma_pkg::ac_t                grant_ac
);

  logic [`CSMA_NUM_AC-1:0] eligible;
  logic                    any_eligible;
  csma_pkg::ac_t           win_ac;

  // a queue granted this cycle still shows ready, so mask it.
  assign eligible     = ready & ~grant;
  assign any_eligible = medium_idle & (|eligible);

  // highest index wins.
  always_comb begin
    win_ac = '0;
    for (int i = 0; i < `CSMA_NUM_AC; i++) begin
      if (eligible[i]) begin
        win_ac = csma_pkg::ac_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      grant    <= '0;
      grant_ac <= '0;
    end else begin
      grant <= any_eligible ? (`CSMA_NUM_AC'(1) << win_ac) : '0;
      // index holds the last granted queue.
      if (any_eligible) begin
        grant_ac <= win_ac;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/backoff_engine.sv
// Per-queue backoff engine
`timescale 1ns/10ps
`default_nettype none

`include "csma_defines.svh"

module backoff_engine #(
  parameter int AIFS_CYCLES = `CSMA_SIFS_CYCLES + 2 * `CSMA_SLOT_CYCLES
) (
  input  wire logic             clk,
  input  wire logic             rstn,
  input  wire logic             tx_req,
  input  wire csma_pkg::slots_t backoff_slots,
  input  wire logic             medium_idle,
  input  wire logic             grant,
  output logic                  ready
);

  localparam int AIFS_W = $clog2(AIFS_CYCLES + 1);
  localparam int SLOT_W = $clog2(`CSMA_SLOT_CYCLES + 1);

  localparam logic [AIFS_W-1:0] AIFS_LAST = AIFS_W'(AIFS_CYCLES - 1);
  localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(`CSMA_SLOT_CYCLES - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_AIFS  = 2'd1;
  localparam logic [1:0] ST_SLOT  = 2'd2;
  localparam logic [1:0] ST_READY = 2'd3;

  logic [1:0]        state;
  logic              tx_req_q;
  logic              req_rise;
  logic [AIFS_W-1:0] aifs_cnt;
  logic [SLOT_W-1:0] slot_cnt;
  csma_pkg::slots_t  slots_left;

  // slots are taken only when a new request starts.
  assign req_rise = tx_req & ~tx_req_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= ST_IDLE;
      tx_req_q   <= 1'b0;
      aifs_cnt   <= '0;
      slot_cnt   <= '0;
      slots_left <= '0;
    end else begin
      tx_req_q <= tx_req;
      if (!tx_req) begin
        state <= ST_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            if (req_rise) begin
              state      <= ST_AIFS;
              aifs_cnt   <= '0;
              slots_left <= backoff_slots;
            end
          end
          ST_AIFS: begin
            // aifs needs an unbroken run of idle cycles.
            if (!medium_idle) begin
              aifs_cnt <= '0;
            end else if (aifs_cnt == AIFS_LAST) begin
              slot_cnt <= '0;
              state    <= (slots_left == '0) ? ST_READY : ST_SLOT;
            end else begin
              aifs_cnt <= aifs_cnt + 1'b1;
            end
          end
          ST_SLOT: begin
            if (!medium_idle) begin
              // partial slot is lost, remaining slots are frozen.
              state    <= ST_AIFS;
              aifs_cnt <= '0;
            end else if (slot_cnt == SLOT_LAST) begin
              slot_cnt   <= '0;
              slots_left <= slots_left - 1'b1;
              if (slots_left == csma_pkg::slots_t'(1)) begin
                state <= ST_READY;
              end
            end else begin
              slot_cnt <= slot_cnt + 1'b1;
            end
          end
          default: begin
            // stays ready through busy periods until granted.
            if (grant) begin
              state <= ST_IDLE;
            end
          end
        endcase
      end
    end
  end

  assign ready = (state == ST_READY);

endmodule

`default_nettype wire

//--- design/cca.sv
// Clear channel assessment
`timescale 1ns/10ps
`default_nettype none

`include "csma_defines.svh"

module cca #(
  parameter int RSSI_HALF_DB_WIDTH = 11
) (
  input  wire logic                                 clk,
  input  wire logic                                 rstn,
  input  wire logic signed [RSSI_HALF_DB_WIDTH-1:0] rssi_half_db,
  input  wire logic signed [RSSI_HALF_DB_WIDTH-1:0] rssi_half_db_th,
  input  wire logic                                 rx_ht_aggr,
  input  wire logic                                 rx_ht_aggr_last,
  input  wire logic                                 demod_is_ongoing,
  input  wire logic                                 tx_rf_is_ongoing,
  input  wire logic                                 cts_toself_rf_is_ongoing,
  input  wire logic                                 ack_cts_is_ongoing,
  input  wire logic                                 fcs_in_strobe,
  input  wire logic [7:0]                           wait_after_decode_top,
  output logic                                      ch_idle
);

  logic [`CSMA_WAIT_W-1:0] wait_top_scale;
  logic [`CSMA_WAIT_W-1:0] wait_count;
  logic                    is_counting;
  logic                    frame_end;
  logic                    ch_idle_rssi;

  // last fcs of a plain frame or of the final subframe of an aggregate.
  assign frame_end = fcs_in_strobe & (~rx_ht_aggr | rx_ht_aggr_last);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wait_top_scale <= '0;
      wait_count     <= '0;
      is_counting    <= 1'b0;
    end else begin
      wait_top_scale <= `CSMA_WAIT_W'(wait_after_decode_top * `CSMA_COUNT_SCALE);
      if (frame_end && (wait_top_scale != '0)) begin
        is_counting <= 1'b1;
        wait_count  <= '0;
      end else if (is_counting) begin
        wait_count <= wait_count + 1'b1;
        // window closes once the count has reached the top.
        if (wait_count >= wait_top_scale) begin
          is_counting <= 1'b0;
        end
      end
    end
  end

  // the medium reads idle during the window regardless of rssi.
  assign ch_idle_rssi = is_counting |
                        ((rssi_half_db <= rssi_half_db_th) & ~demod_is_ongoing);

  // own transmissions always mark the channel busy.
  assign ch_idle = ch_idle_rssi & ~tx_rf_is_ongoing &
                   ~cts_toself_rf_is_ongoing & ~ack_cts_is_ongoing;

endmodule

`default_nettype wire

//--- design/channel_access_top.sv
// Channel access top level
`timescale 1ns/10ps
`default_nettype none

`include "csma_defines.svh"

module channel_access_top #(
  parameter int RSSI_HALF_DB_WIDTH = 11
) (
  input  wire logic                                 clk,
  input  wire logic                                 rstn,
  input  wire logic signed [RSSI_HALF_DB_WIDTH-1:0] rssi_half_db,
  input  wire logic signed [RSSI_HALF_DB_WIDTH-1:0] rssi_half_db_th,
  input  wire logic                                 rx_ht_aggr,
  input  wire logic                                 rx_ht_aggr_last,
  input  wire logic                                 demod_is_ongoing,
  input  wire logic                                 fcs_in_strobe,
  input  wire logic [7:0]                           wait_after_decode_top,
  input  wire logic                                 tx_rf_is_ongoing,
  input  wire logic                                 cts_toself_rf_is_ongoing,
  input  wire logic                                 ack_cts_is_ongoing,
  input  wire logic                                 rx_hdr_valid,
  input  wire csma_pkg::dur_id_u                    rx_dur_id,
  input  wire logic [`CSMA_NUM_AC-1:0]              tx_req,
  input  wire csma_pkg::slots_t [`CSMA_NUM_AC-1:0]  backoff_slots,
  output logic                                      ch_idle,
  output logic                                      nav_busy,
  output logic [`CSMA_NUM_AC-1:0]                   tx_grant,
  output csma_pkg::ac_t                             grant_ac
);

  logic                    medium_idle;
  logic [`CSMA_NUM_AC-1:0] ac_ready;

  cca #(
    .RSSI_HALF_DB_WIDTH(RSSI_HALF_DB_WIDTH)
  ) i_cca (
    .clk                     (clk),
    .rstn                    (rstn),
    .rssi_half_db            (rssi_half_db),
    .rssi_half_db_th         (rssi_half_db_th),
    .rx_ht_aggr              (rx_ht_aggr),
    .rx_ht_aggr_last         (rx_ht_aggr_last),
    .demod_is_ongoing        (demod_is_ongoing),
    .tx_rf_is_ongoing        (tx_rf_is_ongoing),
    .cts_toself_rf_is_ongoing(cts_toself_rf_is_ongoing),
    .ack_cts_is_ongoing      (ack_cts_is_ongoing),
    .fcs_in_strobe           (fcs_in_strobe),
    .wait_after_decode_top   (wait_after_decode_top),
    .ch_idle                 (ch_idle)
  );

  nav_timer i_nav (
    .clk         (clk),
    .rstn        (rstn),
    .rx_hdr_valid(rx_hdr_valid),
    .rx_dur_id   (rx_dur_id),
    .nav_busy    (nav_busy)
  );

  // physical and virtual carrier sense together.
  assign medium_idle = ch_idle & ~nav_busy;

  for (genvar ac = 0; ac < `CSMA_NUM_AC; ac++) begin : g_ac
    localparam int AIFSN = (ac == 3) ? `CSMA_AIFSN_3 :
                           (ac == 2) ? `CSMA_AIFSN_2 :
                           (ac == 1) ? `CSMA_AIFSN_1 : `CSMA_AIFSN_0;

    backoff_engine #(
      .AIFS_CYCLES(`CSMA_SIFS_CYCLES + AIFSN * `CSMA_SLOT_CYCLES)
    ) i_engine (
      .clk          (clk),
      .rstn         (rstn),
      .tx_req       (tx_req[ac]),
      .backoff_slots(backoff_slots[ac]),
      .medium_idle  (medium_idle),
      .grant        (tx_grant[ac]),
      .ready        (ac_ready[ac])
    );
  end

  access_arbiter i_arb (
    .clk        (clk),
    .rstn       (rstn),
    .ready      (ac_ready),
    .medium_idle(medium_idle),
    .grant      (tx_grant),
    .grant_ac   (grant_ac)
  );

endmodule

`default_nettype wire

//--- design/csma_pkg.sv
// Channel access types
`default_nettype none

`include "csma_defines.svh"

package csma_pkg;

  // duration form, top bit clear, value in microseconds.
  typedef struct packed {
    logic        is_aid;
    logic [14:0] dur_us;
  } dur_t;

  // association id form, top two bits set.
  typedef struct packed {
    logic [1:0]  aid_tag;
    logic [13:0] aid;
  } aid_t;

  // received duration/id word of a frame header.
  typedef union packed {
    dur_t dur;
    aid_t aid;
  } dur_id_u;

  // access category index, 3 is the highest priority.
  typedef logic [$clog2(`CSMA_NUM_AC)-1:0] ac_t;

  // number of backoff slots drawn for one queue.
  typedef logic [`CSMA_SLOT_W-1:0] slots_t;

endpackage

`default_nettype wire

//--- design/nav_timer.sv
// Network allocation vector
`timescale 1ns/10ps
`default_nettype none

`include "csma_defines.svh"

module nav_timer (
  input  wire logic              clk,
  input  wire logic              rstn,
  input  wire logic              rx_hdr_valid,
  input  wire csma_pkg::dur_id_u rx_dur_id,
  output logic                   nav_busy
);

  logic [`CSMA_NAV_W-1:0] nav_count;
  logic [`CSMA_NAV_W-1:0] nav_new;
  logic                   take_dur;

  // only the duration form reserves the medium.
  assign take_dur = rx_hdr_valid & ~rx_dur_id.dur.is_aid;

  // microseconds to clock cycles.
  assign nav_new = `CSMA_NAV_W'(rx_dur_id.dur.dur_us * `CSMA_COUNT_SCALE);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      nav_count <= '0;
    end else if (take_dur && (nav_new > nav_count)) begin
      // a longer reservation replaces the remaining one.
      nav_count <= nav_new;
    end else if (nav_count != '0) begin
      nav_count <= nav_count - 1'b1;
    end
  end

  assign nav_busy = (nav_count != '0);

endmodule

`default_nettype wire

//--- dv/channel_access_properties.sv
// Channel access assertions
`timescale 1ns/10ps
`default_nettype none

`include "csma_defines.svh"

module channel_access_properties (
  input wire logic                    clk,
  input wire logic                    rstn,
  input wire logic                    medium_idle,
  input wire logic [`CSMA_NUM_AC-1:0] tx_req,
  input wire logic [`CSMA_NUM_AC-1:0] tx_grant
);

  // at most one queue owns the medium.
  grant_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0(tx_grant))
    else $error("tx_grant has more than one bit set");

  // grants come only out of an idle cycle.
  grant_after_idle: assert property (@(posedge clk) disable iff (!rstn)
    (tx_grant != '0) |-> $past(medium_idle))
    else $error("tx_grant issued after a busy medium cycle");

  // a granted queue was requesting in the cycle before.
  grant_needs_req: assert property (@(posedge clk) disable iff (!rstn)
    (tx_grant & ~$past(tx_req)) == '0)
    else $error("tx_grant issued to a queue without tx_req");

endmodule

`default_nettype wire

//--- dv/channel_access_tb.sv
// Channel access testbench
`timescale 1ns/10ps
`default_nettype none

`include "csma_defines.svh"

module channel_access_tb;

  localparam int CLK_PERIOD = 100;
  localparam int NAC        = `CSMA_NUM_AC;
  localparam int SCALE      = `CSMA_COUNT_SCALE;
  localparam int LEN_CCA    = 400;
  localparam int LEN_WINDOW = 1500;
  localparam int LEN_NAV    = 2000;
  localparam int LEN_SINGLE = 2500;
  localparam int LEN_BURST  = 2500;
  localparam int LEN_MULTI  = 3000;
  localparam int RUN_CYCLES = 4 + LEN_CCA + LEN_WINDOW + LEN_NAV + LEN_SINGLE +
                              LEN_BURST + LEN_MULTI;

  // engine model states.
  localparam int E_IDLE  = 0;
  localparam int E_AIFS  = 1;
  localparam int E_SLOT  = 2;
  localparam int E_READY = 3;

  logic                         clk;
  logic                         rstn;
  logic signed [10:0]           rssi_half_db;
  logic signed [10:0]           rssi_half_db_th;
  logic                         rx_ht_aggr;
  logic                         rx_ht_aggr_last;
  logic                         demod_is_ongoing;
  logic                         fcs_in_strobe;
  logic [7:0]                   wait_after_decode_top;
  logic                         tx_rf_is_ongoing;
  logic                         cts_toself_rf_is_ongoing;
  logic                         ack_cts_is_ongoing;
  logic                         rx_hdr_valid;
  csma_pkg::dur_id_u            rx_dur_id;
  logic [NAC-1:0]               tx_req;
  csma_pkg::slots_t [NAC-1:0]   backoff_slots;
  logic                         ch_idle;
  logic                         nav_busy;
  logic [NAC-1:0]               tx_grant;
  csma_pkg::ac_t                grant_ac;

  // cycle model state.
  int             m_top;
  int             m_wcnt;
  logic           m_counting;
  int             m_nav;
  int             m_state [NAC];
  int             m_run [NAC];
  int             m_scnt [NAC];
  int             m_left [NAC];
  logic [NAC-1:0] m_req_q;
  logic [NAC-1:0] m_grant;
  csma_pkg::ac_t  m_ac;

  logic [31:0] lfsr_state = 32'hd481_dad1;
  int          burst_left;
  int          grants_seen;
  int          bit_errors;
  int          grant_errors;
  int          ac_errors;
  int          other_errors;

  channel_access_top i_dut (.*);

  bind channel_access_top channel_access_properties i_props (
    .clk        (clk),
    .rstn       (rstn),
    .medium_idle(medium_idle),
    .tx_req     (tx_req),
    .tx_grant   (tx_grant)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((RUN_CYCLES + 200) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("Some tests failed");
    $finish;
  end

  // galois lfsr, one step per bit taken.
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // true with probability 1 in 2**n.
  function automatic logic chance(int n);
    return rand_bits(n) == 0;
  endfunction

  function automatic int aifs_of(int n);
    int aifsn;
    case (n)
      3:       aifsn = `CSMA_AIFSN_3;
      2:       aifsn = `CSMA_AIFSN_2;
      1:       aifsn = `CSMA_AIFSN_1;
      default: aifsn = `CSMA_AIFSN_0;
    endcase
    return `CSMA_SIFS_CYCLES + aifsn * `CSMA_SLOT_CYCLES;
  endfunction

  function automatic logic expected_ch_idle();
    logic quiet;
    quiet = (rssi_half_db <= rssi_half_db_th) && !demod_is_ongoing;
    return (m_counting || quiet) && !tx_rf_is_ongoing &&
           !cts_toself_rf_is_ongoing && !ack_cts_is_ongoing;
  endfunction

  task automatic step_engine(int n, logic idle);
    if (!tx_req[n]) begin
      m_state[n] = E_IDLE;
    end else begin
      case (m_state[n])
        E_IDLE: begin
          if (!m_req_q[n]) begin
            m_state[n] = E_AIFS;
            m_run[n]   = 0;
            m_left[n]  = int'(backoff_slots[n]);
          end
        end
        E_AIFS: begin
          if (!idle) begin
            m_run[n] = 0;
          end else begin
            m_run[n]++;
            if (m_run[n] == aifs_of(n)) begin
              m_scnt[n]  = 0;
              m_state[n] = (m_left[n] == 0) ? E_READY : E_SLOT;
            end
          end
        end
        E_SLOT: begin
          if (!idle) begin
            m_state[n] = E_AIFS;
            m_run[n]   = 0;
          end else begin
            m_scnt[n]++;
            if (m_scnt[n] == `CSMA_SLOT_CYCLES) begin
              m_scnt[n] = 0;
              m_left[n]--;
              if (m_left[n] == 0) begin
                m_state[n] = E_READY;
              end
            end
          end
        end
        default: begin
          if (m_grant[n]) begin
            m_state[n] = E_IDLE;
          end
        end
      endcase
    end
    m_req_q[n] = tx_req[n];
  endtask

  // advance the model by one clock using the inputs of the cycle that ends.
  task automatic model_step();
    logic           idle;
    logic           frame_end;
    logic [NAC-1:0] grant_next;
    int             win;
    int             nav_new;
    idle = expected_ch_idle() && (m_nav == 0);
    win  = -1;
    for (int n = 0; n < NAC; n++) begin
      if ((m_state[n] == E_READY) && !m_grant[n]) begin
        win = n;
      end
    end
    grant_next = '0;
    if (idle && (win >= 0)) begin
      grant_next[win] = 1'b1;
      m_ac            = csma_pkg::ac_t'(win);
      grants_seen++;
    end
    for (int n = 0; n < NAC; n++) begin
      step_engine(n, idle);
    end
    m_grant = grant_next;
    frame_end = fcs_in_strobe && (!rx_ht_aggr || rx_ht_aggr_last);
    if (frame_end && (m_top != 0)) begin
      m_counting = 1'b1;
      m_wcnt     = 0;
    end else if (m_counting) begin
      if (m_wcnt >= m_top) begin
        m_counting = 1'b0;
      end
      m_wcnt++;
    end
    m_top   = int'(wait_after_decode_top) * SCALE;
    nav_new = int'(rx_dur_id.dur.dur_us) * SCALE;
    if (rx_hdr_valid && !rx_dur_id.dur.is_aid && (nav_new > m_nav)) begin
      m_nav = nav_new;
    end else if (m_nav != 0) begin
      m_nav--;
    end
  endtask

  task automatic drive_quiet_medium();
    rssi_half_db             <= -11'sd400;
    rssi_half_db_th          <= -11'sd160;
    demod_is_ongoing         <= 1'b0;
    fcs_in_strobe            <= 1'b0;
    tx_rf_is_ongoing         <= 1'b0;
    cts_toself_rf_is_ongoing <= 1'b0;
    ack_cts_is_ongoing       <= 1'b0;
    rx_hdr_valid             <= 1'b0;
  endtask

  task automatic drive_queues(int ph, logic [NAC-1:0] prev_grant);
    int q;
    // busy bursts from the demodulator.
    if (ph >= 5) begin
      if (burst_left > 0) begin
        burst_left--;
      end else if (chance(6)) begin
        burst_left = 1 + int'(rand_bits(5));
      end
      demod_is_ongoing <= (burst_left > 0);
    end
    for (int n = 0; n < NAC; n++) begin
      if (prev_grant[n]) begin
        tx_req[n] <= 1'b0;
      end
    end
    if (ph == 6) begin
      for (int n = 0; n < NAC; n++) begin
        if (!tx_req[n] && ((tx_req == '0) || chance(5))) begin
          tx_req[n]        <= 1'b1;
          backoff_slots[n] <= csma_pkg::slots_t'(rand_bits(3));
        end
      end
    end else if ((tx_req == '0) && chance(2)) begin
      q                = int'(rand_bits(2));
      tx_req[q]        <= 1'b1;
      backoff_slots[q] <= csma_pkg::slots_t'(rand_bits(4));
    end
  endtask

  task automatic drive_cycle(int ph, logic [NAC-1:0] prev_grant);
    csma_pkg::dur_id_u word;
    drive_quiet_medium();
    case (ph)
      1: begin
        rssi_half_db             <= 11'(rand_bits(11));
        rssi_half_db_th          <= 11'(rand_bits(11));
        demod_is_ongoing         <= 1'(rand_bits(1));
        tx_rf_is_ongoing         <= chance(3);
        cts_toself_rf_is_ongoing <= chance(3);
        ack_cts_is_ongoing       <= chance(3);
      end
      2: begin
        // rssi above the threshold, so only the window shows idle.
        rssi_half_db             <= 11'(rand_bits(6));
        demod_is_ongoing         <= 1'(rand_bits(1));
        fcs_in_strobe            <= chance(4);
        rx_ht_aggr               <= 1'(rand_bits(1));
        rx_ht_aggr_last          <= 1'(rand_bits(1));
        tx_rf_is_ongoing         <= chance(5);
        cts_toself_rf_is_ongoing <= chance(6);
        ack_cts_is_ongoing       <= chance(6);
        if (chance(6)) begin
          wait_after_decode_top <= 8'(rand_bits(4));
        end
      end
      3: begin
        if (chance(4)) begin
          if (rand_bits(1) != 0) begin
            word.dur.is_aid = 1'b0;
            word.dur.dur_us = 15'(rand_bits(6));
          end else begin
            word.aid.aid_tag = 2'b11;
            word.aid.aid     = 14'(rand_bits(14));
          end
          rx_hdr_valid <= 1'b1;
          rx_dur_id    <= word;
        end
      end
      default: drive_queues(ph, prev_grant);
    endcase
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      bit_errors++;
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_grant(logic [NAC-1:0] got, logic [NAC-1:0] exp);
    if (got !== exp) begin
      grant_errors++;
      $display("error at %0t: tx_grant is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic compare_ac(csma_pkg::ac_t got, csma_pkg::ac_t exp);
    if (got !== exp) begin
      ac_errors++;
      $display("error at %0t: grant_ac is %0d, expected %0d", $time, got, exp);
    end
  endtask

  task automatic run_phase(int ph, int cycles);
    logic [NAC-1:0] prev_grant;
    repeat (cycles) begin
      @(posedge clk);
      prev_grant = m_grant;
      model_step();
      drive_cycle(ph, prev_grant);
      // outputs are settled half a period after the edge.
      @(negedge clk);
      compare_bit("ch_idle", ch_idle, expected_ch_idle());
      compare_bit("nav_busy", nav_busy, m_nav != 0);
      compare_grant(tx_grant, m_grant);
      compare_ac(grant_ac, m_ac);
    end
  endtask

  initial begin
    rstn                     = 1'b0;
    rssi_half_db             = '0;
    rssi_half_db_th          = '0;
    rx_ht_aggr               = 1'b0;
    rx_ht_aggr_last          = 1'b0;
    demod_is_ongoing         = 1'b0;
    fcs_in_strobe            = 1'b0;
    wait_after_decode_top    = 8'd5;
    tx_rf_is_ongoing         = 1'b0;
    cts_toself_rf_is_ongoing = 1'b0;
    ack_cts_is_ongoing       = 1'b0;
    rx_hdr_valid             = 1'b0;
    rx_dur_id                = '0;
    tx_req                   = '0;
    backoff_slots            = '0;
    m_top      = 0;
    m_wcnt     = 0;
    m_counting = 1'b0;
    m_nav      = 0;
    m_req_q    = '0;
    m_grant    = '0;
    m_ac       = '0;
    for (int n = 0; n < NAC; n++) begin
      m_state[n] = E_IDLE;
      m_run[n]   = 0;
      m_scnt[n]  = 0;
      m_left[n]  = 0;
    end
    burst_left   = 0;
    grants_seen  = 0;
    bit_errors   = 0;
    grant_errors = 0;
    ac_errors    = 0;
    other_errors = 0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    run_phase(1, LEN_CCA);
    run_phase(2, LEN_WINDOW);
    run_phase(3, LEN_NAV);
    run_phase(4, LEN_SINGLE);
    run_phase(5, LEN_BURST);
    run_phase(6, LEN_MULTI);
    if (grants_seen == 0) begin
      other_errors++;
      $display("no queue was granted during the whole run");
    end
    $display("error counts: carrier sense %0d, grant %0d, grant_ac %0d, other %0d",
             bit_errors, grant_errors, ac_errors, other_errors);
    if ((bit_errors + grant_errors + ac_errors + other_errors) == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- include/csma_defines.svh
// Channel access constants
`ifndef CSMA_DEFINES_SVH
`define CSMA_DEFINES_SVH

// clock cycles per microsecond.
// Both the post-decode window and the NAV use this scale.
`define CSMA_COUNT_SCALE 10

// interframe timing in clock cycles.
`define CSMA_SLOT_CYCLES 9
`define CSMA_SIFS_CYCLES 16

// aifs slot numbers per access category.
// Queue 0 is background and queue 3 is voice.
`define CSMA_AIFSN_0 7
`define CSMA_AIFSN_1 3
`define CSMA_AIFSN_2 2
`define CSMA_AIFSN_3 2

// number of transmit queues.
`define CSMA_NUM_AC 4

// backoff slot count width.
`define CSMA_SLOT_W 10

// nav counter width, enough for 32767 us at the cycle scale.
`define CSMA_NAV_W 20

// post-decode wait counter width, an 8-bit top times the scale.
`define CSMA_WAIT_W 12

`endif

//--- run.sh
#!/bin/sh
# Verilator build and run of the channel access testbench.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module channel_access_tb \
  -f sources.f -o channel_access_sim &&
{ ./obj_dir/channel_access_sim > sim.log 2>&1 ||
  echo "simulation exited with an error" >> sim.log; } &&
cat sim.log &&
! grep -q "Some tests failed" sim.log &&
grep -q "All tests passed" sim.log ||
{ echo "simulation failed, see sim.log"; exit 1; }

//--- sources.f
+incdir+include
design/csma_pkg.sv
design/cca.sv
design/nav_timer.sv
design/backoff_engine.sv
design/access_arbiter.sv
design/channel_access_top.sv
dv/channel_access_properties.sv
dv/channel_access_tb.sv
